/* Makefile */
# Verilator build and run of the dispatch queue testbench.
# The run's exit status is the pass or fail result.

VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := alu_mdu_dq_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* alu_mdu_dq.sv */
/*
  ALU reg-reg and multiply-divide dispatch queue, top level.
  Up to DISPATCH_WAYS ops per cycle enter, acked in way order; the oldest
  leaves through a valid/ready handshake to the issue queue.
  dispatch_ack is combinational on attempt and valid.
  Incoming ops keep their ready bits as given, with no same-cycle wakeup.
*/

`timescale 1ns/1ps

module alu_mdu_dq import core_params_pkg::*, dq_pkg::*; #(
    parameter int DQ_ENTRIES    = 4,
    parameter int DISPATCH_WAYS = 4
) (
    input  logic                           CLK,
    input  logic                           nRST,

    // dispatch, per way
    input  logic     [DISPATCH_WAYS-1:0]   dispatch_attempt,
    input  logic     [DISPATCH_WAYS-1:0]   dispatch_valid,
    input  logic     [DISPATCH_WAYS-1:0]   dispatch_is_mdu,
    input  op_code_t [DISPATCH_WAYS-1:0]   dispatch_op,
    input  pr_t      [DISPATCH_WAYS-1:0]   dispatch_a_pr,
    input  logic     [DISPATCH_WAYS-1:0]   dispatch_a_ready,
    input  pr_t      [DISPATCH_WAYS-1:0]   dispatch_b_pr,
    input  logic     [DISPATCH_WAYS-1:0]   dispatch_b_ready,
    input  pr_t      [DISPATCH_WAYS-1:0]   dispatch_dest_pr,
    input  rob_idx_t [DISPATCH_WAYS-1:0]   dispatch_rob_index,
    output logic     [DISPATCH_WAYS-1:0]   dispatch_ack,

    // writeback bus
    input  logic      [PRF_BANK_COUNT-1:0] wb_valid_by_bank,
    input  pr_upper_t [PRF_BANK_COUNT-1:0] wb_upper_pr_by_bank,

    // issue queue enqueue
    output logic                           iq_enq_valid,
    output logic                           iq_enq_is_mdu,
    output op_code_t                       iq_enq_op,
    output pr_t                            iq_enq_a_pr,
    output logic                           iq_enq_a_ready,
    output pr_t                            iq_enq_b_pr,
    output logic                           iq_enq_b_ready,
    output pr_t                            iq_enq_dest_pr,
    output rob_idx_t                       iq_enq_rob_index,
    input  logic                           iq_enq_ready
);

    dq_op_t [DISPATCH_WAYS-1:0] way_op;
    logic   [DQ_ENTRIES-1:0]    entry_valid;
    logic   [DQ_ENTRIES-1:0]    wr_en;
    dq_op_t [DQ_ENTRIES-1:0]    wr_op;
    dq_op_t                     head_op;

    // pack dispatch fields per way
    always_comb begin
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            way_op[w].is_mdu    = dispatch_is_mdu[w];
            way_op[w].op        = dispatch_op[w];
            way_op[w].a_pr      = dispatch_a_pr[w];
            way_op[w].a_ready   = dispatch_a_ready[w];
            way_op[w].b_pr      = dispatch_b_pr[w];
            way_op[w].b_ready   = dispatch_b_ready[w];
            way_op[w].dest_pr   = dispatch_dest_pr[w];
            way_op[w].rob_index = dispatch_rob_index[w];
        end
    end

    dq_dispatch #(
        .DQ_ENTRIES    (DQ_ENTRIES),
        .DISPATCH_WAYS (DISPATCH_WAYS)
    ) dispatch (
        .entry_valid      (entry_valid),
        .dispatch_attempt (dispatch_attempt),
        .dispatch_valid   (dispatch_valid),
        .dispatch_op      (way_op),
        .dispatch_ack     (dispatch_ack),
        .wr_en            (wr_en),
        .wr_op            (wr_op)
    );

    dq_entries #(
        .DQ_ENTRIES(DQ_ENTRIES)
    ) entries (
        .CLK                 (CLK),
        .nRST                (nRST),
        .wr_en               (wr_en),
        .wr_op               (wr_op),
        .wb_valid_by_bank    (wb_valid_by_bank),
        .wb_upper_pr_by_bank (wb_upper_pr_by_bank),
        .entry_valid         (entry_valid),
        .iq_enq_valid        (iq_enq_valid),
        .iq_enq_op           (head_op),
        .iq_enq_ready        (iq_enq_ready)
    );

    // unpack head onto plain outputs
    assign iq_enq_is_mdu    = head_op.is_mdu;
    assign iq_enq_op        = head_op.op;
    assign iq_enq_a_pr      = head_op.a_pr;
    assign iq_enq_a_ready   = head_op.a_ready;
    assign iq_enq_b_pr      = head_op.b_pr;
    assign iq_enq_b_ready   = head_op.b_ready;
    assign iq_enq_dest_pr   = head_op.dest_pr;
    assign iq_enq_rob_index = head_op.rob_index;

endmodule

/* alu_mdu_dq_sva.sv */
/*
  Handshake checks on the dispatch queue top level, attached by bind.
  Looks at the internal head_op of the top level for the payload check.
  Inputs are expected to change away from the rising clock edge.
*/

`timescale 1ns/1ps

module alu_mdu_dq_sva import core_params_pkg::*, dq_pkg::*; #(
    parameter int DISPATCH_WAYS = 4
) (
    input logic                     CLK,
    input logic                     nRST,
    input logic [DISPATCH_WAYS-1:0] dispatch_attempt,
    input logic [DISPATCH_WAYS-1:0] dispatch_valid,
    input logic [DISPATCH_WAYS-1:0] dispatch_ack,
    input logic                     iq_enq_valid,
    input logic                     iq_enq_ready,
    input dq_op_t                   head
);

    // head fields that must not move while stalled
    logic [$bits(dq_op_t)-3:0] head_fixed;
    logic [1:0]                head_ready;

    assign head_fixed = {head.is_mdu, head.op, head.a_pr, head.b_pr,
                         head.dest_pr, head.rob_index};
    assign head_ready = {head.a_ready, head.b_ready};

    // queue comes out of reset empty
    assert property (@(posedge CLK) !nRST |=> !iq_enq_valid)
        else $error("iq_enq_valid high in the cycle after reset");

    // ready bits may only rise under back-pressure
    assert property (@(posedge CLK) disable iff (!nRST)
        iq_enq_valid && !iq_enq_ready |=> iq_enq_valid && $stable(head_fixed)
            && (($past(head_ready) & ~head_ready) == 2'b00))
        else $error("head changed while the issue queue was stalled");

    assert property (@(posedge CLK) disable iff (!nRST)
        (dispatch_ack & ~dispatch_attempt) == '0)
        else $error("dispatch_ack without an attempt");

    for (genvar w = 0; w < DISPATCH_WAYS; w++) begin : g_order
        assert property (@(posedge CLK) disable iff (!nRST)
            dispatch_attempt[w] && dispatch_valid[w] && !dispatch_ack[w]
                |-> (dispatch_ack >> (w + 1)) == '0)
            else $error("way %0d refused but a higher way was acked", w);
    end

endmodule

bind alu_mdu_dq alu_mdu_dq_sva #(
    .DISPATCH_WAYS(DISPATCH_WAYS)
) sva (
    .CLK              (CLK),
    .nRST             (nRST),
    .dispatch_attempt (dispatch_attempt),
    .dispatch_valid   (dispatch_valid),
    .dispatch_ack     (dispatch_ack),
    .iq_enq_valid     (iq_enq_valid),
    .iq_enq_ready     (iq_enq_ready),
    .head             (head_op)
);

/* alu_mdu_dq_tb.sv */
/*
  Random testbench for the dispatch queue at its default parameters.
  Inputs change 2 ns after the rising edge, outputs are compared 2 ns
  before it against a queue model. Runs until N_OPS ops have left.
*/

`timescale 1ns/1ps

module alu_mdu_dq_tb import core_params_pkg::*, dq_pkg::*;;

    localparam int DQ_ENTRIES      = 4;
    localparam int DISPATCH_WAYS   = 4;
    localparam int N_OPS           = 400;
    localparam int RESET_CYCLES    = 16;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20 * N_OPS;

    logic                                CLK;
    logic                                nRST;
    logic      [DISPATCH_WAYS-1:0]       dispatch_attempt;
    logic      [DISPATCH_WAYS-1:0]       dispatch_valid;
    logic      [DISPATCH_WAYS-1:0]       dispatch_is_mdu;
    op_code_t  [DISPATCH_WAYS-1:0]       dispatch_op;
    pr_t       [DISPATCH_WAYS-1:0]       dispatch_a_pr;
    logic      [DISPATCH_WAYS-1:0]       dispatch_a_ready;
    pr_t       [DISPATCH_WAYS-1:0]       dispatch_b_pr;
    logic      [DISPATCH_WAYS-1:0]       dispatch_b_ready;
    pr_t       [DISPATCH_WAYS-1:0]       dispatch_dest_pr;
    rob_idx_t  [DISPATCH_WAYS-1:0]       dispatch_rob_index;
    logic      [DISPATCH_WAYS-1:0]       dispatch_ack;
    logic      [PRF_BANK_COUNT-1:0]      wb_valid_by_bank;
    pr_upper_t [PRF_BANK_COUNT-1:0]      wb_upper_pr_by_bank;
    logic                                iq_enq_valid;
    logic                                iq_enq_is_mdu;
    op_code_t                            iq_enq_op;
    pr_t                                 iq_enq_a_pr;
    logic                                iq_enq_a_ready;
    pr_t                                 iq_enq_b_pr;
    logic                                iq_enq_b_ready;
    pr_t                                 iq_enq_dest_pr;
    rob_idx_t                            iq_enq_rob_index;
    logic                                iq_enq_ready;

    dq_op_t   model_q[$];
    int       n_done;
    int       cycle;
    logic     running;
    rob_idx_t next_rob;

    alu_mdu_dq UUT (.*);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // ------------------------------------------------------------
    // reference model

    function automatic logic [DISPATCH_WAYS-1:0] expected_acks(
        input logic [DISPATCH_WAYS-1:0] attempt,
        input logic [DISPATCH_WAYS-1:0] valid,
        input int free
    );
        logic [DISPATCH_WAYS-1:0] acks;
        int                       need;
        acks = '0;
        need = 0;
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            if (attempt[w] && valid[w]) need++;
            acks[w] = attempt[w] && (need <= free);
        end
        return acks;
    endfunction

    function automatic logic woken(input pr_t pr);
        logic [LOG_PRF_BANK_COUNT-1:0] bank;
        bank = pr[LOG_PRF_BANK_COUNT-1:0];
        return wb_valid_by_bank[bank]
               && (wb_upper_pr_by_bank[bank] == pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]);
    endfunction

    function automatic dq_op_t way_entry(input int w);
        dq_op_t e;
        e.is_mdu    = dispatch_is_mdu[w];
        e.op        = dispatch_op[w];
        e.a_pr      = dispatch_a_pr[w];
        e.a_ready   = dispatch_a_ready[w];
        e.b_pr      = dispatch_b_pr[w];
        e.b_ready   = dispatch_b_ready[w];
        e.dest_pr   = dispatch_dest_pr[w];
        e.rob_index = dispatch_rob_index[w];
        return e;
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %0h actual %0h",
                     $time, name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // compare outputs, then step the model across the coming edge
    task automatic compare_cycle();
        dq_op_t                   head;
        dq_op_t                   tmp;
        logic [DISPATCH_WAYS-1:0] acks;
        acks = expected_acks(dispatch_attempt, dispatch_valid, DQ_ENTRIES - model_q.size());
        check("dispatch_ack", 64'(acks), 64'(dispatch_ack));
        check("iq_enq_valid", 64'(model_q.size() != 0), 64'(iq_enq_valid));
        if (model_q.size() != 0) begin
            head = model_q[0];
            head.a_ready = head.a_ready | woken(head.a_pr);
            head.b_ready = head.b_ready | woken(head.b_pr);
            check("iq_enq_is_mdu", 64'(head.is_mdu), 64'(iq_enq_is_mdu));
            check("iq_enq_op", 64'(head.op), 64'(iq_enq_op));
            check("iq_enq_a_pr", 64'(head.a_pr), 64'(iq_enq_a_pr));
            check("iq_enq_a_ready", 64'(head.a_ready), 64'(iq_enq_a_ready));
            check("iq_enq_b_pr", 64'(head.b_pr), 64'(iq_enq_b_pr));
            check("iq_enq_b_ready", 64'(head.b_ready), 64'(iq_enq_b_ready));
            check("iq_enq_dest_pr", 64'(head.dest_pr), 64'(iq_enq_dest_pr));
            check("iq_enq_rob_index", 64'(head.rob_index), 64'(iq_enq_rob_index));
        end
        // sticky wakeup on held ops only
        foreach (model_q[i]) begin
            tmp = model_q[i];
            tmp.a_ready = tmp.a_ready | woken(tmp.a_pr);
            tmp.b_ready = tmp.b_ready | woken(tmp.b_pr);
            model_q[i] = tmp;
        end
        if (model_q.size() != 0 && iq_enq_ready) begin
            void'(model_q.pop_front());
            n_done++;
        end
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            if (acks[w] && dispatch_valid[w]) model_q.push_back(way_entry(w));
        end
    endtask

    // ------------------------------------------------------------
    // stimulus

    task automatic clear_inputs();
        dispatch_attempt    = '0;
        dispatch_valid      = '0;
        dispatch_is_mdu     = '0;
        dispatch_op         = '0;
        dispatch_a_pr       = '0;
        dispatch_a_ready    = '0;
        dispatch_b_pr       = '0;
        dispatch_b_ready    = '0;
        dispatch_dest_pr    = '0;
        dispatch_rob_index  = '0;
        wb_valid_by_bank    = '0;
        wb_upper_pr_by_bank = '0;
        iq_enq_ready        = 1'b0;
    endtask

    // registers come from a pool of 16 so that wakeups hit often
    task automatic randomize_inputs(input logic stall);
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            dispatch_attempt[w]   = ($urandom_range(0, 99) < 70);
            dispatch_valid[w]     = ($urandom_range(0, 99) < 80);
            dispatch_is_mdu[w]    = 1'($urandom);
            dispatch_op[w]        = op_code_t'($urandom);
            dispatch_a_pr[w]      = pr_t'($urandom_range(0, 15));
            dispatch_a_ready[w]   = ($urandom_range(0, 99) < 30);
            dispatch_b_pr[w]      = pr_t'($urandom_range(0, 15));
            dispatch_b_ready[w]   = ($urandom_range(0, 99) < 30);
            dispatch_dest_pr[w]   = pr_t'($urandom);
            dispatch_rob_index[w] = next_rob;
            next_rob              = rob_idx_t'(next_rob + 1);
        end
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            wb_valid_by_bank[b]    = ($urandom_range(0, 99) < 35);
            wb_upper_pr_by_bank[b] = pr_upper_t'($urandom_range(0, 3));
        end
        iq_enq_ready = !stall && ($urandom_range(0, 99) < 60);
    endtask

    initial begin
        forever begin
            @(posedge CLK);
            #18;
            if (running) compare_cycle();
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("watchdog expired before all operations left the queue");
        $display("Testbench failed");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(32'h3074));
        nRST     = 1'b0;
        running  = 1'b0;
        n_done   = 0;
        cycle    = 0;
        next_rob = '0;
        clear_inputs();
        repeat (RESET_CYCLES) @(posedge CLK);
        #2;
        nRST    = 1'b1;
        running = 1'b1;
        // full-width burst into the empty queue
        @(posedge CLK);
        #2;
        randomize_inputs(1'b1);
        dispatch_attempt = '1;
        dispatch_valid   = '1;
        // long stall window fills the queue
        while (n_done < N_OPS) begin
            @(posedge CLK);
            #2;
            cycle++;
            randomize_inputs(cycle >= 150 && cycle < 210);
        end
        // drain
        @(posedge CLK);
        #2;
        clear_inputs();
        iq_enq_ready = 1'b1;
        while (model_q.size() != 0) begin
            @(posedge CLK);
            #2;
        end
        repeat (2) @(posedge CLK);
        #2;
        check("iq_enq_valid", 64'(1'b0), 64'(iq_enq_valid));
        $display("Testbench passed");
        $finish;
    end

endmodule

/* core_params_pkg.sv */
/*
  Core-wide widths shared by the dispatch queue and its neighbours.
  A physical register number splits into low bank select bits and the
  upper bits that travel on the writeback bus of that bank.
  PRF_BANK_COUNT must stay equal to 2**LOG_PRF_BANK_COUNT.
*/

package core_params_pkg;

    // ------------------------------------------------------------
    // widths

    // physical register number
    localparam int LOG_PR_COUNT = 7;

    // reorder buffer index
    localparam int LOG_ROB_ENTRIES = 7;

    // writeback banks, selected by the low bits of a register number
    localparam int LOG_PRF_BANK_COUNT = 2;
    localparam int PRF_BANK_COUNT     = 1 << LOG_PRF_BANK_COUNT;

    // ------------------------------------------------------------
    // types

    typedef logic [LOG_PR_COUNT-1:0] pr_t;

    typedef logic [LOG_ROB_ENTRIES-1:0] rob_idx_t;

    // register number without bank bits, as carried per bank on writeback
    typedef logic [LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] pr_upper_t;

endpackage

/* dq_dispatch.sv */
/*
  Dispatch side of the queue, fully combinational.
  Assumes the valid entries are packed at the bottom with no gaps.
  Entries freed by a launch in the same cycle are not offered.
  The ack path grows with DISPATCH_WAYS chained pickers.
*/

`timescale 1ns/1ps

module dq_dispatch import dq_pkg::*; #(
    parameter int DQ_ENTRIES    = 4,
    parameter int DISPATCH_WAYS = 4
) (
    input  logic   [DQ_ENTRIES-1:0]    entry_valid,

    // per way
    input  logic   [DISPATCH_WAYS-1:0] dispatch_attempt,
    input  logic   [DISPATCH_WAYS-1:0] dispatch_valid,
    input  dq_op_t [DISPATCH_WAYS-1:0] dispatch_op,
    output logic   [DISPATCH_WAYS-1:0] dispatch_ack,

    // per entry
    output logic   [DQ_ENTRIES-1:0]    wr_en,
    output dq_op_t [DQ_ENTRIES-1:0]    wr_op
);

    logic [DISPATCH_WAYS-1:0]                 need_slot;
    logic [DISPATCH_WAYS-1:0][DQ_ENTRIES-1:0] grant;

    // an attempt with valid low takes no entry
    assign need_slot = dispatch_attempt & dispatch_valid;

    // ------------------------------------------------------------
    // grant chain

    always_comb begin
        logic [DQ_ENTRIES-1:0] open_mask;
        logic [DQ_ENTRIES-1:0] lowest_open;
        logic                  blocked;

        open_mask = ~entry_valid;
        blocked   = 1'b0;

        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            // isolate lowest set bit
            lowest_open = open_mask & (~open_mask + DQ_ENTRIES'(1));
            grant[w]    = lowest_open & {DQ_ENTRIES{need_slot[w]}};

            // once a slot user misses, every later way is refused
            dispatch_ack[w] = dispatch_attempt[w] & ~blocked
                              & (~need_slot[w] | (|open_mask));

            blocked   = blocked | (need_slot[w] & ~(|open_mask));
            open_mask = open_mask & ~grant[w];
        end
    end

    // ------------------------------------------------------------
    // route granted payloads to entries

    // grants are one-hot per entry, so an AND-OR mux is enough
    always_comb begin
        wr_en = '0;
        wr_op = '0;
        for (int e = 0; e < DQ_ENTRIES; e++) begin
            for (int w = 0; w < DISPATCH_WAYS; w++) begin
                wr_en[e] = wr_en[e] | grant[w][e];
                wr_op[e] = wr_op[e]
                           | (dispatch_op[w] & {$bits(dq_op_t){grant[w][e]}});
            end
        end
    end

endmodule

/* dq_entries.sv */
/*
  Collapsing entry storage. Entry 0 is the oldest and feeds the issue queue.
  Only the valid bits are reset. An empty entry's payload is undefined.
  On a launch all entries shift down by one, and writes granted this
  cycle land one entry below their grant.
  Under back-pressure the head holds, except that ready bits may rise.
*/

`timescale 1ns/1ps

module dq_entries import core_params_pkg::*, dq_pkg::*; #(
    parameter int DQ_ENTRIES = 4
) (
    input  logic                       CLK,
    input  logic                       nRST,

    // writes from dispatch
    input  logic      [DQ_ENTRIES-1:0] wr_en,
    input  dq_op_t    [DQ_ENTRIES-1:0] wr_op,

    // writeback bus
    input  logic      [PRF_BANK_COUNT-1:0] wb_valid_by_bank,
    input  pr_upper_t [PRF_BANK_COUNT-1:0] wb_upper_pr_by_bank,

    output logic      [DQ_ENTRIES-1:0] entry_valid,

    // head to issue queue
    output logic                       iq_enq_valid,
    output dq_op_t                     iq_enq_op,
    input  logic                       iq_enq_ready
);

    logic   [DQ_ENTRIES-1:0] valid_q;
    logic   [DQ_ENTRIES-1:0] valid_d;
    dq_op_t [DQ_ENTRIES-1:0] op_q;
    dq_op_t [DQ_ENTRIES-1:0] op_d;

    // stored ops with this cycle's wakeup merged in
    dq_op_t [DQ_ENTRIES-1:0] held_op;
    pr_t    [DQ_ENTRIES-1:0] entry_a_pr;
    pr_t    [DQ_ENTRIES-1:0] entry_b_pr;
    logic   [DQ_ENTRIES-1:0] a_wake;
    logic   [DQ_ENTRIES-1:0] b_wake;

    // per-entry source after the optional shift
    logic   [DQ_ENTRIES-1:0] src_valid;
    logic   [DQ_ENTRIES-1:0] src_wr_en;
    dq_op_t [DQ_ENTRIES-1:0] src_held;
    dq_op_t [DQ_ENTRIES-1:0] src_wr_op;

    logic launching;

    // ------------------------------------------------------------
    // wakeup

    dq_wakeup #(
        .DQ_ENTRIES(DQ_ENTRIES)
    ) wakeup (
        .a_pr                (entry_a_pr),
        .b_pr                (entry_b_pr),
        .wb_valid_by_bank    (wb_valid_by_bank),
        .wb_upper_pr_by_bank (wb_upper_pr_by_bank),
        .a_wake              (a_wake),
        .b_wake              (b_wake)
    );

    always_comb begin
        for (int i = 0; i < DQ_ENTRIES; i++) begin
            entry_a_pr[i]      = op_q[i].a_pr;
            entry_b_pr[i]      = op_q[i].b_pr;
            held_op[i]         = op_q[i];
            held_op[i].a_ready = op_q[i].a_ready | a_wake[i];
            held_op[i].b_ready = op_q[i].b_ready | b_wake[i];
        end
    end

    // ------------------------------------------------------------
    // launch and next state

    assign launching = valid_q[0] & iq_enq_ready;

    // on launch each entry looks one above, the top one sees nothing
    always_comb begin
        if (launching) begin
            src_valid = {1'b0, valid_q[DQ_ENTRIES-1:1]};
            src_wr_en = {1'b0, wr_en[DQ_ENTRIES-1:1]};
            src_held  = {{$bits(dq_op_t){1'b0}}, held_op[DQ_ENTRIES-1:1]};
            src_wr_op = {{$bits(dq_op_t){1'b0}}, wr_op[DQ_ENTRIES-1:1]};
        end else begin
            src_valid = valid_q;
            src_wr_en = wr_en;
            src_held  = held_op;
            src_wr_op = wr_op;
        end
    end

    // writes only target free entries, so held ops win cleanly
    assign valid_d = src_valid | src_wr_en;

    always_comb begin
        for (int i = 0; i < DQ_ENTRIES; i++) begin
            op_d[i] = src_valid[i] ? src_held[i] : src_wr_op[i];
        end
    end

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge CLK) begin
        op_q <= op_d;
    end

    // ------------------------------------------------------------
    // outputs

    assign entry_valid  = valid_q;
    assign iq_enq_valid = valid_q[0];
    assign iq_enq_op    = held_op[0];

endmodule

/* dq_pkg.sv */
/*
  Record of one operation held in the ALU/MDU dispatch queue.
  The ready bits are sticky while the operation is held.
  is_mdu selects the multiply-divide class, ALU otherwise.
*/

package dq_pkg;

    import core_params_pkg::*;

    // operation code within its class
    typedef logic [3:0] op_code_t;

    // ------------------------------------------------------------
    // queued operation

    typedef struct packed {
        logic     is_mdu;
        op_code_t op;
        // source operand A
        pr_t      a_pr;
        logic     a_ready;
        // source operand B
        pr_t      b_pr;
        logic     b_ready;
        // result register and ROB slot
        pr_t      dest_pr;
        rob_idx_t rob_index;
    } dq_op_t;

endpackage

/* dq_wakeup.sv */
/*
  Operand wakeup against the banked writeback bus.
  Combinational, two tag compares per entry.
  Valid or not, every entry is compared; callers qualify the result.
*/

`timescale 1ns/1ps

module dq_wakeup import core_params_pkg::*; #(
    parameter int DQ_ENTRIES = 4
) (
    input  pr_t       [DQ_ENTRIES-1:0]     a_pr,
    input  pr_t       [DQ_ENTRIES-1:0]     b_pr,
    input  logic      [PRF_BANK_COUNT-1:0] wb_valid_by_bank,
    input  pr_upper_t [PRF_BANK_COUNT-1:0] wb_upper_pr_by_bank,
    output logic      [DQ_ENTRIES-1:0]     a_wake,
    output logic      [DQ_ENTRIES-1:0]     b_wake
);

    always_comb begin
        logic [LOG_PRF_BANK_COUNT-1:0] a_bank;
        logic [LOG_PRF_BANK_COUNT-1:0] b_bank;
        pr_upper_t                     a_upper;
        pr_upper_t                     b_upper;

        for (int i = 0; i < DQ_ENTRIES; i++) begin
            a_bank  = a_pr[i][LOG_PRF_BANK_COUNT-1:0];
            a_upper = a_pr[i][LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
            b_bank  = b_pr[i][LOG_PRF_BANK_COUNT-1:0];
            b_upper = b_pr[i][LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];

            // bank picks the bus lane, upper bits must match its tag
            a_wake[i] = wb_valid_by_bank[a_bank]
                        & (wb_upper_pr_by_bank[a_bank] == a_upper);
            b_wake[i] = wb_valid_by_bank[b_bank]
                        & (wb_upper_pr_by_bank[b_bank] == b_upper);
        end
    end

endmodule

/* project.f */
core_params_pkg.sv
dq_pkg.sv
dq_wakeup.sv
dq_dispatch.sv
dq_entries.sv
alu_mdu_dq.sv
alu_mdu_dq_sva.sv
alu_mdu_dq_tb.sv
